//--- design/conv_geom_pkg.sv
`default_nettype none

package conv_geom_pkg;

	localparam int COORD_W = 8; // map size up to 255
	localparam int TAPS    = 9; // 3x3 window

	typedef logic [COORD_W-1:0] coord_t;

	// bit 8 top-left ... bit 0 bottom-right, row-major
	typedef logic [TAPS-1:0] tap_mask_t;

	typedef struct packed {
		coord_t row;
		coord_t col;
	} tap_addr_t;

	// tap 0 (top-left) sits in the top bits
	typedef tap_addr_t [0:TAPS-1] tap_addr_vec_t;

	typedef struct packed {
		tap_addr_vec_t taps;
		tap_mask_t     mask;
		logic          pool_last; // 4th window of a 2x2 group
	} read_req_t;

endpackage

`default_nettype wire

//--- design/scan_pkg.sv
`default_nettype none

package scan_pkg;

	typedef enum logic {
		ST_IDLE,
		ST_SCAN
	} scan_state_e;

	// visiting order inside one pooling group
	typedef enum logic [1:0] {
		PH_TL = 2'd0, // (0,0)
		PH_BL = 2'd1, // row +1
		PH_BR = 2'd2, // row +1, col +1
		PH_TR = 2'd3  // col +1
	} pool_phase_e;

	typedef struct packed {
		conv_geom_pkg::coord_t row;
		conv_geom_pkg::coord_t col;
		pool_phase_e           phase;
		logic                  last; // final window of the map
	} window_pos_t;

endpackage

`default_nettype wire

//--- design/window_scan.sv
`default_nettype none

module window_scan #(
	parameter int MAP_W = 8,
	parameter int MAP_H = 8
) (
	input  wire                  clk,
	input  wire                  i_rst_n,
	input  wire                  i_start,
	output scan_pkg::window_pos_t o_pos,
	output logic                 o_pos_valid
);

	localparam conv_geom_pkg::coord_t LAST_PAIR = conv_geom_pkg::coord_t'(MAP_W - 2);
	localparam conv_geom_pkg::coord_t LAST_BAND = conv_geom_pkg::coord_t'(MAP_H - 2);

	scan_pkg::scan_state_e state;
	scan_pkg::pool_phase_e phase;
	conv_geom_pkg::coord_t band_row; // top row of the current two-row band
	conv_geom_pkg::coord_t pair_col; // left column of the current pair
	logic                  at_end;
	logic                  row_off;
	logic                  col_off;

	assign at_end = (phase == scan_pkg::PH_TR) && (pair_col == LAST_PAIR) &&
		(band_row == LAST_BAND);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= scan_pkg::ST_IDLE;
			phase    <= scan_pkg::PH_TL;
			band_row <= '0;
			pair_col <= '0;
		end else if (state == scan_pkg::ST_IDLE) begin
			if (i_start) begin
				state    <= scan_pkg::ST_SCAN;
				phase    <= scan_pkg::PH_TL;
				band_row <= '0;
				pair_col <= '0;
			end
		end else begin
			phase <= scan_pkg::pool_phase_e'(phase + 2'd1); // TR wraps to TL
			if (phase == scan_pkg::PH_TR) begin
				if (pair_col == LAST_PAIR) begin
					pair_col <= '0;
					if (band_row == LAST_BAND)
						band_row <= '0;
					else
						band_row <= band_row + conv_geom_pkg::coord_t'(2);
				end else begin
					pair_col <= pair_col + conv_geom_pkg::coord_t'(2);
				end
			end
			if (at_end)
				state <= scan_pkg::ST_IDLE; // last window goes out this cycle
		end
	end

	// phase offsets within the 2x2 group
	assign row_off = (phase == scan_pkg::PH_BL) || (phase == scan_pkg::PH_BR);
	assign col_off = (phase == scan_pkg::PH_BR) || (phase == scan_pkg::PH_TR);

	always_comb begin
		o_pos.row   = band_row + conv_geom_pkg::coord_t'(row_off);
		o_pos.col   = pair_col + conv_geom_pkg::coord_t'(col_off);
		o_pos.phase = phase;
		o_pos.last  = at_end;
	end

	assign o_pos_valid = (state == scan_pkg::ST_SCAN);

endmodule

`default_nettype wire

//--- design/tap_addr_gen.sv
`default_nettype none

module tap_addr_gen (
	input  scan_pkg::window_pos_t        i_pos,
	output conv_geom_pkg::tap_addr_vec_t o_taps
);

	conv_geom_pkg::coord_t row_m1;
	conv_geom_pkg::coord_t row_p1;
	conv_geom_pkg::coord_t col_m1;
	conv_geom_pkg::coord_t col_p1;
	conv_geom_pkg::coord_t rows [3];
	conv_geom_pkg::coord_t cols [3];

	// wraps at the edges, masked later
	assign row_m1 = i_pos.row - conv_geom_pkg::coord_t'(1);
	assign row_p1 = i_pos.row + conv_geom_pkg::coord_t'(1);
	assign col_m1 = i_pos.col - conv_geom_pkg::coord_t'(1);
	assign col_p1 = i_pos.col + conv_geom_pkg::coord_t'(1);

	always_comb begin
		rows[0] = row_m1;
		rows[1] = i_pos.row;
		rows[2] = row_p1;
		cols[0] = col_m1;
		cols[1] = i_pos.col;
		cols[2] = col_p1;
	end

	// row-major, tap 0 top-left
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				o_taps[r*3 + c].row = rows[r];
				o_taps[r*3 + c].col = cols[c];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/pad_mask_gen.sv
`default_nettype none

module pad_mask_gen #(
	parameter int MAP_W = 8,
	parameter int MAP_H = 8
) (
	input  scan_pkg::window_pos_t    i_pos,
	output conv_geom_pkg::tap_mask_t o_mask
);

	localparam conv_geom_pkg::coord_t LAST_ROW = conv_geom_pkg::coord_t'(MAP_H - 1);
	localparam conv_geom_pkg::coord_t LAST_COL = conv_geom_pkg::coord_t'(MAP_W - 1);

	logic [2:0] row_en; // [0] top, [1] centre, [2] bottom
	logic [2:0] col_en; // [0] left, [1] centre, [2] right

	// one-pixel zero padding, corners fall out of the product
	always_comb begin
		row_en[0] = (i_pos.row != '0);
		row_en[1] = 1'b1;
		row_en[2] = (i_pos.row != LAST_ROW);
		col_en[0] = (i_pos.col != '0);
		col_en[1] = 1'b1;
		col_en[2] = (i_pos.col != LAST_COL);
	end

	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				// tap t lives at bit TAPS-1-t
				o_mask[conv_geom_pkg::TAPS - 1 - (r*3 + c)] = row_en[r] & col_en[c];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/read_issue.sv
`default_nettype none

module read_issue (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  conv_geom_pkg::tap_addr_vec_t i_taps,
	input  conv_geom_pkg::tap_mask_t     i_mask,
	input  scan_pkg::window_pos_t        i_pos,
	input  wire                          i_pos_valid,
	output conv_geom_pkg::read_req_t     o_req,
	output logic                         o_valid,
	output logic                         o_done
);

	conv_geom_pkg::read_req_t req_d;
	logic                     last_q; // last window of the map in o_req

	always_comb begin
		req_d.mask      = i_pos_valid ? i_mask : '0;
		req_d.pool_last = (i_pos.phase == scan_pkg::PH_TR);
		for (int t = 0; t < conv_geom_pkg::TAPS; t++) begin
			if (req_d.mask[conv_geom_pkg::TAPS - 1 - t])
				req_d.taps[t] = i_taps[t];
			else
				req_d.taps[t] = '0; // padded tap
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_req   <= '0;
			o_valid <= 1'b0;
			o_done  <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			o_req   <= req_d;
			o_valid <= i_pos_valid;
			last_q  <= i_pos_valid && i_pos.last;
			o_done  <= o_valid && last_q; // cycle after the final request
		end
	end

endmodule

`default_nettype wire

//--- design/conv_read_seq.sv
`default_nettype none

module conv_read_seq #(
	parameter int MAP_W = 8, // even, at most 255
	parameter int MAP_H = 8
) (
	input  wire                      clk,
	input  wire                      i_rst_n,
	input  wire                      i_start,
	output conv_geom_pkg::read_req_t o_req,
	output logic                     o_valid,
	output logic                     o_done
);

	scan_pkg::window_pos_t        pos;
	logic                         pos_valid;
	conv_geom_pkg::tap_addr_vec_t taps;
	conv_geom_pkg::tap_mask_t     mask;

	window_scan #(
		.MAP_W (MAP_W),
		.MAP_H (MAP_H)
	) u_window_scan (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.o_pos       (pos),
		.o_pos_valid (pos_valid)
	);

	tap_addr_gen u_tap_addr_gen (
		.i_pos  (pos),
		.o_taps (taps)
	);

	pad_mask_gen #(
		.MAP_W (MAP_W),
		.MAP_H (MAP_H)
	) u_pad_mask_gen (
		.i_pos  (pos),
		.o_mask (mask)
	);

	read_issue u_read_issue (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_taps      (taps),
		.i_mask      (mask),
		.i_pos       (pos),
		.i_pos_valid (pos_valid),
		.o_req       (o_req),
		.o_valid     (o_valid),
		.o_done      (o_done)
	);

endmodule

`default_nettype wire

//--- verif/conv_read_seq_asserts.sv
`default_nettype none

module conv_read_seq_asserts (
	input wire                      clk,
	input wire                      i_rst_n,
	input wire                      i_start,
	input conv_geom_pkg::read_req_t i_req,
	input wire                      i_valid,
	input wire                      i_done
);

	// done comes a cycle after the last request
	done_apart_from_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_done && i_valid))
		else $error("o_done and o_valid high in the same cycle");

	pool_last_with_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_req.pool_last |-> i_valid)
		else $error("pool_last set without o_valid");

	// a restart sampled right after the final window refills the pipe
	quiet_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
		($past(i_done) && !$past(i_start, 2)) |-> !i_valid)
		else $error("o_valid high in the cycle after o_done without a new start");

endmodule

bind conv_read_seq conv_read_seq_asserts u_asserts (
	.clk     (clk),
	.i_rst_n (i_rst_n),
	.i_start (i_start),
	.i_req   (o_req),
	.i_valid (o_valid),
	.i_done  (o_done)
);

`default_nettype wire

//--- verif/tb_conv_read_seq.sv
`default_nettype none

module tb_conv_read_seq;

	localparam int MAP_W = 8;
	localparam int MAP_H = 4;
	localparam int DEPTH = 128;

	localparam logic [3:0] REC_START  = 4'h1; // start after an idle gap
	localparam logic [3:0] REC_BUMP   = 4'h2; // extra start inside the scan
	localparam logic [3:0] REC_WINDOW = 4'h3;
	localparam logic [3:0] REC_END    = 4'hf;

	logic                     clk;
	logic                     i_rst_n;
	logic                     i_start;
	conv_geom_pkg::read_req_t req;
	logic                     valid;
	logic                     done;

	logic [35:0] patterns [DEPTH];
	int cycle_count = 0;
	int timeout_cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;
	int group_row = 0; // top-left of the current 2x2 group
	int group_col = 0;

	conv_read_seq #(
		.MAP_W (MAP_W),
		.MAP_H (MAP_H)
	) u_dut (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_start (i_start),
		.o_req   (req),
		.o_valid (valid),
		.o_done  (done)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
			$display("timeout: no end of run after %0d cycles", timeout_cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// outputs settle right after the edge, inputs change at the same point
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic open_test();
		test_start_errors = errors;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_start_errors);
		end
	endtask

	// taps outside the map are padding
	function automatic logic [8:0] padded_mask(input int row, input int col);
		logic [8:0] m;
		int rr;
		int cc;
		for (int t = 0; t < 9; t++) begin
			rr = row + t / 3 - 1;
			cc = col + t % 3 - 1;
			m[8 - t] = (rr >= 0) && (rr < MAP_H) && (cc >= 0) && (cc < MAP_W);
		end
		return m;
	endfunction

	task automatic idle_cycle();
		tick();
		compare("o_valid", 32'(valid), 32'd0);
		compare("o_done", 32'(done), 32'd0);
	endtask

	task automatic verify_window(input int k, input logic [35:0] rec);
		int row;
		int col;
		int got_row;
		int got_col;
		int er;
		int ec;
		logic [8:0] exp_mask;
		logic [1:0] ph;
		row = int'(rec[31:24]);
		col = int'(rec[23:16]);
		got_row = int'(req.taps[4].row);
		got_col = int'(req.taps[4].col);
		exp_mask = padded_mask(row, col);
		ph = 2'(k % 4);
		compare("o_valid", 32'(valid), 32'd1);
		compare("o_done", 32'(done), 32'd0);
		compare("o_req.taps[4].row", 32'(req.taps[4].row), 32'(row));
		compare("o_req.taps[4].col", 32'(req.taps[4].col), 32'(col));
		compare("o_req.mask", 32'(req.mask), 32'(rec[8:0]));
		compare("o_req.mask from centre", 32'(req.mask), 32'(exp_mask));
		compare("o_req.pool_last", 32'(req.pool_last), 32'(rec[12]));
		compare("o_req.pool_last on 4th", 32'(req.pool_last), 32'(ph == 2'd3));
		for (int t = 0; t < 9; t++) begin
			if (exp_mask[8 - t]) begin
				er = row + t / 3 - 1;
				ec = col + t % 3 - 1;
			end else begin
				er = 0;
				ec = 0;
			end
			compare($sformatf("o_req.taps[%0d].row", t), 32'(req.taps[t].row), 32'(er));
			compare($sformatf("o_req.taps[%0d].col", t), 32'(req.taps[t].col), 32'(ec));
		end
		// TL, BL, BR, TR around an even base
		if (ph == 2'd0) begin
			group_row = got_row;
			group_col = got_col;
			compare("group base row parity", 32'(got_row % 2), 32'd0);
			compare("group base col parity", 32'(got_col % 2), 32'd0);
		end
		compare("group row offset", 32'(got_row - group_row), 32'(ph == 2'd1 || ph == 2'd2));
		compare("group col offset", 32'(got_col - group_col), 32'(ph == 2'd2 || ph == 2'd3));
	endtask

	task automatic run_scan(input int gap, input int bump_at, input int first, input int n_win);
		repeat (gap) idle_cycle();
		i_start = 1'b1;
		tick();
		i_start = 1'b0;
		compare("o_valid", 32'(valid), 32'd0); // one edge in, nothing yet
		compare("o_done", 32'(done), 32'd0);
		tick();
		for (int k = 0; k < n_win; k++) begin
			verify_window(k, patterns[first + k]);
			i_start = (k == bump_at);
			tick();
		end
		i_start = 1'b0;
		compare("o_valid", 32'(valid), 32'd0);
		compare("o_done", 32'(done), 32'd1);
	endtask

	initial begin
		int idx;
		int gap;
		int bump_at;
		int first;
		int n_scans;
		int gap_total;
		int scan_no;

		i_rst_n = 1'b0;
		i_start = 1'b0;
		n_scans = 0;
		gap_total = 0;
		scan_no = 0;
		$readmemh("verif/read_patterns.hex", patterns);
		for (idx = 0; idx < DEPTH && patterns[idx][35:32] != REC_END; idx++) begin
			if (patterns[idx][35:32] == REC_START) begin
				n_scans++;
				gap_total += int'(patterns[idx][15:0]);
			end
		end
		timeout_cycles = 2 * (n_scans * MAP_W * MAP_H + gap_total) + 50;

		open_test();
		repeat (8) begin
			tick();
			compare("o_valid", 32'(valid), 32'd0);
			compare("o_done", 32'(done), 32'd0);
			compare("o_req.mask", 32'(req.mask), 32'd0);
		end
		i_rst_n = 1'b1;
		tick();
		compare("o_valid", 32'(valid), 32'd0);
		compare("o_done", 32'(done), 32'd0);
		compare("o_req.mask", 32'(req.mask), 32'd0);
		close_test("reset");

		if (n_scans == 0) begin
			$display("pattern file holds no scan");
			errors++;
		end
		idx = 0;
		while (idx < DEPTH && patterns[idx][35:32] == REC_START) begin
			gap = int'(patterns[idx][15:0]);
			idx++;
			bump_at = -1;
			if (patterns[idx][35:32] == REC_BUMP) begin
				bump_at = int'(patterns[idx][15:0]);
				idx++;
			end
			first = idx;
			while (idx < DEPTH && patterns[idx][35:32] == REC_WINDOW)
				idx++;
			scan_no++;
			open_test();
			if (idx - first != MAP_W * MAP_H) begin
				$display("scan %0d: pattern file lists %0d windows instead of %0d",
					scan_no, idx - first, MAP_W * MAP_H);
				errors++;
			end
			run_scan(gap, bump_at, first, idx - first);
			close_test($sformatf("scan %0d", scan_no));
		end
		if (idx >= DEPTH || patterns[idx][35:32] != REC_END) begin
			$display("pattern file has an unexpected record at index %0d", idx);
			errors++;
		end

		open_test();
		repeat (4) idle_cycle(); // done must not repeat
		close_test("idle after scans");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/read_patterns.hex
// 1 0000 gggg start after gggg idle cycles; 2 0000 nnnn extra start after window nnnn
// 3 rr cc p mmm window centre row rr, col cc, pool_last p, tap mask mmm; f0000000 end
100000004
200000009
30000001B
3010000DB
3010101FF
30001103F
30002003F
3010201FF
3010301FF
30003103F
30004003F
3010401FF
3010501FF
30005103F
30006003F
3010601FF
3010701B6
300071036
3020000DB
3030000D8
3030101F8
3020111FF
3020201FF
3030201F8
3030301F8
3020311FF
3020401FF
3030401F8
3030501F8
3020511FF
3020601FF
3030601F8
3030701B0
3020711B6
100000000
30000001B
3010000DB
3010101FF
30001103F
30002003F
3010201FF
3010301FF
30003103F
30004003F
3010401FF
3010501FF
30005103F
30006003F
3010601FF
3010701B6
300071036
3020000DB
3030000D8
3030101F8
3020111FF
3020201FF
3030201F8
3030301F8
3020311FF
3020401FF
3030401F8
3030501F8
3020511FF
3020601FF
3030601F8
3030701B0
3020711B6
F00000000

//--- tb.f
design/conv_geom_pkg.sv
design/scan_pkg.sv
design/window_scan.sv
design/tap_addr_gen.sv
design/pad_mask_gen.sv
design/read_issue.sv
design/conv_read_seq.sv
verif/conv_read_seq_asserts.sv
verif/tb_conv_read_seq.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_conv_read_seq -f tb.f
./obj_dir/Vtb_conv_read_seq > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0
